// File: include/regcon_defines.svh
`ifndef REGCON_DEFINES_SVH
`define REGCON_DEFINES_SVH

////////////////////////////////////////////////////////////
// Register file geometry
////////////////////////////////////////////////////////////

`define REGCON_REG_COUNT 32
`define REGCON_ADDR_W 5
`define REGCON_DATA_W 16

// One knob step carries one nibble
`define REGCON_NIBBLE_W 4

////////////////////////////////////////////////////////////
// Display
////////////////////////////////////////////////////////////

// 16 characters of 8 bits
`define REGCON_LINE_W 128

`define REGCON_CHAR_ZERO 8'h30
`define REGCON_CHAR_ONE 8'h31

`endif

// File: src/regcon_pkg.sv
`include "regcon_defines.svh"

package regcon_pkg;

        // Opcodes 3 and 4 are not part of the console
        typedef enum logic [2:0] {
                write    = 3'd0,
                read     = 3'd1,
                read_two = 3'd2,
                compare  = 3'd5,
                xor_op   = 3'd6,
                shift    = 3'd7
        } opcode_e;

        typedef logic [`REGCON_ADDR_W-1:0] reg_addr_t;
        typedef logic [`REGCON_DATA_W-1:0] reg_word_t;

        typedef struct packed {
                logic                        pad;
                logic [`REGCON_NIBBLE_W-1:0] amount;
        } shift_view_t;

        // Second operand: a source address, or a shift amount for shift
        typedef union packed {
                reg_addr_t   addr;
                shift_view_t shift_view;
        } operand_u;

        typedef struct packed {
                opcode_e   opcode;
                reg_addr_t src_a;
                operand_u  src_b;
                reg_addr_t dest;
                reg_word_t data;
        } console_cmd_t;

        typedef struct packed {
                logic      valid;
                reg_word_t line1_word;
                reg_word_t line2_word;
        } display_req_t;

        typedef struct packed {
                logic      en;
                reg_addr_t addr;
                reg_word_t data;
        } reg_wr_t;

endpackage

// File: src/command_entry.sv
`timescale 1ns/1ps
`include "regcon_defines.svh"

module command_entry (
        input  logic                        clk,
        input  logic                        reset,
        input  logic                        rot,
        input  logic [`REGCON_NIBBLE_W-1:0] bits,
        output regcon_pkg::console_cmd_t    cmd,
        output logic                        cmd_valid
);
        import regcon_pkg::*;

        logic       rot_prev;
        logic       step;
        logic       op_ok;
        logic       start;
        logic       busy;
        logic [2:0] field_cnt;
        logic       last_step;
        logic [1:0] data_sel;

        // Rising edge of the knob
        assign step  = rot & ~rot_prev;
        assign op_ok = (bits[2:0] != 3'd3) && (bits[2:0] != 3'd4);
        assign start = step & ~busy & op_ok;

        // Data nibbles arrive on counts 2..5
        assign data_sel = field_cnt[1:0] - 2'd2;

        always_comb begin
                case (cmd.opcode)
                        write:    last_step = (field_cnt == 3'd5);
                        read:     last_step = (field_cnt == 3'd1);
                        read_two: last_step = (field_cnt == 3'd3);
                        shift:    last_step = (field_cnt == 3'd4);
                        default:  last_step = (field_cnt == 3'd5);
                endcase
        end

        ////////////////////////////////////////////////////////////
        // Control
        ////////////////////////////////////////////////////////////

        always_ff @(posedge clk) begin
                if (reset) begin
                        rot_prev  <= 1'b0;
                        busy      <= 1'b0;
                        field_cnt <= '0;
                        cmd_valid <= 1'b0;
                end else begin
                        rot_prev  <= rot;
                        cmd_valid <= 1'b0;
                        if (start) begin
                                busy      <= 1'b1;
                                field_cnt <= '0;
                        end else if (step && busy) begin
                                field_cnt <= field_cnt + 3'd1;
                                if (last_step) begin
                                        busy      <= 1'b0;
                                        cmd_valid <= 1'b1;
                                end
                        end
                end
        end

        ////////////////////////////////////////////////////////////
        // Field capture
        ////////////////////////////////////////////////////////////

        always_ff @(posedge clk) begin
                if (start) begin
                        cmd.opcode <= opcode_e'(bits[2:0]);
                end else if (step && busy) begin
                        if (cmd.opcode == write) begin
                                case (field_cnt)
                                        3'd0:    cmd.dest[3:0] <= bits;
                                        3'd1:    cmd.dest[4] <= bits[0];
                                        default: cmd.data[{data_sel, 2'b00} +: 4] <= bits;
                                endcase
                        end else if (cmd.opcode == shift) begin
                                case (field_cnt)
                                        3'd0: cmd.src_a[3:0] <= bits;
                                        3'd1: cmd.src_a[4] <= bits[0];
                                        3'd2: begin
                                                cmd.src_b.shift_view.amount <= bits;
                                                cmd.src_b.shift_view.pad    <= 1'b0;
                                        end
                                        3'd3:    cmd.dest[3:0] <= bits;
                                        default: cmd.dest[4] <= bits[0];
                                endcase
                        end else begin
                                // Read, read two, compare and XOR share one order
                                case (field_cnt)
                                        3'd0:    cmd.src_a[3:0] <= bits;
                                        3'd1:    cmd.src_a[4] <= bits[0];
                                        3'd2:    cmd.src_b.addr[3:0] <= bits;
                                        3'd3:    cmd.src_b.addr[4] <= bits[0];
                                        3'd4:    cmd.dest[3:0] <= bits;
                                        default: cmd.dest[4] <= bits[0];
                                endcase
                        end
                end
        end

endmodule

// File: src/reg_file.sv
`timescale 1ns/1ps
`include "regcon_defines.svh"

module reg_file (
        input  logic                   clk,
        input  logic                   reset,
        input  regcon_pkg::reg_addr_t  rd_addr_a,
        input  regcon_pkg::reg_addr_t  rd_addr_b,
        input  regcon_pkg::reg_wr_t    wr,
        output regcon_pkg::reg_word_t  rd_data_a,
        output regcon_pkg::reg_word_t  rd_data_b
);
        import regcon_pkg::*;

        reg_word_t mem [0:`REGCON_REG_COUNT-1];

        ////////////////////////////////////////////////////////////
        // Storage
        ////////////////////////////////////////////////////////////

        // Console starts with every register at zero
        always_ff @(posedge clk) begin
                if (reset) begin
                        for (int i = 0; i < `REGCON_REG_COUNT; i++) begin
                                mem[i] <= '0;
                        end
                end else if (wr.en) begin
                        mem[wr.addr] <= wr.data;
                end
        end

        ////////////////////////////////////////////////////////////
        // Read ports
        ////////////////////////////////////////////////////////////

        assign rd_data_a = mem[rd_addr_a];
        assign rd_data_b = mem[rd_addr_b];

endmodule

// File: src/op_execute.sv
`timescale 1ns/1ps

module op_execute (
        input  logic                     clk,
        input  logic                     reset,
        input  regcon_pkg::console_cmd_t cmd,
        input  logic                     cmd_valid,
        input  regcon_pkg::reg_word_t    rd_data_a,
        input  regcon_pkg::reg_word_t    rd_data_b,
        output regcon_pkg::reg_addr_t    rd_addr_a,
        output regcon_pkg::reg_addr_t    rd_addr_b,
        output regcon_pkg::reg_wr_t      wr,
        output regcon_pkg::display_req_t disp
);
        import regcon_pkg::*;

        reg_word_t eq_word;
        reg_word_t xor_word;
        reg_word_t shift_word;
        reg_word_t result;
        reg_word_t line1_word;
        reg_word_t line2_word;
        logic      writes_reg;

        // Command fields stay put until the next command
        assign rd_addr_a = cmd.src_a;
        assign rd_addr_b = cmd.src_b.addr;

        ////////////////////////////////////////////////////////////
        // Datapath
        ////////////////////////////////////////////////////////////

        assign eq_word    = (rd_data_a == rd_data_b) ? reg_word_t'(1) : '0;
        assign xor_word   = rd_data_a ^ rd_data_b;
        assign shift_word = rd_data_a >> cmd.src_b.shift_view.amount;

        always_comb begin
                case (cmd.opcode)
                        compare: result = eq_word;
                        xor_op:  result = xor_word;
                        shift:   result = shift_word;
                        default: result = cmd.data;
                endcase
        end

        assign writes_reg = (cmd.opcode == write) || (cmd.opcode == compare) ||
                            (cmd.opcode == xor_op) || (cmd.opcode == shift);

        // What the two display lines show
        always_comb begin
                case (cmd.opcode)
                        read: begin
                                line1_word = reg_word_t'(cmd.src_a);
                                line2_word = rd_data_a;
                        end
                        read_two: begin
                                line1_word = rd_data_a;
                                line2_word = rd_data_b;
                        end
                        default: begin
                                line1_word = reg_word_t'(cmd.dest);
                                line2_word = result;
                        end
                endcase
        end

        ////////////////////////////////////////////////////////////
        // Write-back and display request
        ////////////////////////////////////////////////////////////

        always_ff @(posedge clk) begin
                if (reset) begin
                        wr.en      <= 1'b0;
                        disp.valid <= 1'b0;
                end else begin
                        wr.en      <= cmd_valid & writes_reg;
                        disp.valid <= cmd_valid;
                end
        end

        always_ff @(posedge clk) begin
                if (cmd_valid) begin
                        wr.addr         <= cmd.dest;
                        wr.data         <= result;
                        disp.line1_word <= line1_word;
                        disp.line2_word <= line2_word;
                end
        end

endmodule

// File: src/lcd_line_format.sv
`timescale 1ns/1ps
`include "regcon_defines.svh"

module lcd_line_format (
        input  logic                      clk,
        input  logic                      reset,
        input  regcon_pkg::display_req_t  disp,
        output logic [`REGCON_LINE_W-1:0] line1,
        output logic [`REGCON_LINE_W-1:0] line2
);
        import regcon_pkg::*;

        logic [`REGCON_LINE_W-1:0] text1;
        logic [`REGCON_LINE_W-1:0] text2;

        // One character per bit, MSB in the leftmost cell
        function automatic logic [`REGCON_LINE_W-1:0] render(input reg_word_t word);
                logic [`REGCON_LINE_W-1:0] text;
                for (int i = 0; i < `REGCON_DATA_W; i++) begin
                        text[i*8 +: 8] = word[i] ? `REGCON_CHAR_ONE : `REGCON_CHAR_ZERO;
                end
                return text;
        endfunction

        assign text1 = render(disp.line1_word);
        assign text2 = render(disp.line2_word);

        ////////////////////////////////////////////////////////////
        // Line registers
        ////////////////////////////////////////////////////////////

        // Lines hold between requests
        always_ff @(posedge clk) begin
                if (reset) begin
                        line1 <= '0;
                        line2 <= '0;
                end else if (disp.valid) begin
                        line1 <= text1;
                        line2 <= text2;
                end
        end

endmodule

// File: src/register_console_top.sv
`timescale 1ns/1ps
`include "regcon_defines.svh"

module register_console_top (
        input  logic                        clk,
        input  logic                        reset,
        input  logic                        rot,
        input  logic [`REGCON_NIBBLE_W-1:0] bits,
        output logic [`REGCON_LINE_W-1:0]   line1,
        output logic [`REGCON_LINE_W-1:0]   line2
);
        import regcon_pkg::*;

        console_cmd_t cmd;
        logic         cmd_valid;
        reg_addr_t    rd_addr_a;
        reg_addr_t    rd_addr_b;
        reg_word_t    rd_data_a;
        reg_word_t    rd_data_b;
        reg_wr_t      wr;
        display_req_t disp;

        ////////////////////////////////////////////////////////////
        // Knob entry, execution, display
        ////////////////////////////////////////////////////////////

        command_entry u_command_entry (
                .clk       (clk),
                .reset     (reset),
                .rot       (rot),
                .bits      (bits),
                .cmd       (cmd),
                .cmd_valid (cmd_valid)
        );

        reg_file u_reg_file (
                .clk       (clk),
                .reset     (reset),
                .rd_addr_a (rd_addr_a),
                .rd_addr_b (rd_addr_b),
                .wr        (wr),
                .rd_data_a (rd_data_a),
                .rd_data_b (rd_data_b)
        );

        op_execute u_op_execute (
                .clk       (clk),
                .reset     (reset),
                .cmd       (cmd),
                .cmd_valid (cmd_valid),
                .rd_data_a (rd_data_a),
                .rd_data_b (rd_data_b),
                .rd_addr_a (rd_addr_a),
                .rd_addr_b (rd_addr_b),
                .wr        (wr),
                .disp      (disp)
        );

        lcd_line_format u_lcd_line_format (
                .clk   (clk),
                .reset (reset),
                .disp  (disp),
                .line1 (line1),
                .line2 (line2)
        );

endmodule

// File: test/register_console_asserts.sv
`timescale 1ns/1ps

module register_console_asserts (
        input logic                clk,
        input logic                reset,
        input logic                cmd_valid,
        input regcon_pkg::reg_wr_t wr
);

        ////////////////////////////////////////////////////////////
        // Command and write-back timing
        ////////////////////////////////////////////////////////////

        // Command pulse lasts one clock
        a_cmd_valid_pulse: assert property (
                @(posedge clk) disable iff (reset) cmd_valid |=> !cmd_valid)
                else $error("cmd_valid high for two cycles in a row");

        a_no_write_in_reset: assert property (
                @(posedge clk) reset |=> !wr.en)
                else $error("register write issued while reset is high");

        // Write-back is one clock behind the command
        a_write_after_cmd: assert property (
                @(posedge clk) disable iff (reset) wr.en |-> $past(cmd_valid))
                else $error("write enable without cmd_valid one cycle before");

endmodule

// File: test/register_console_tb.sv
`timescale 1ns/1ps
`include "regcon_defines.svh"

module register_console_tb;
        import regcon_pkg::*;

        localparam string VEC_FILE = "test/register_console_input.txt";

        typedef struct packed {
                logic [2:0]                op;
                reg_addr_t                 src_a;
                reg_addr_t                 src_b;
                reg_addr_t                 dest;
                reg_word_t                 data;
                logic [`REGCON_LINE_W-1:0] line1;
                logic [`REGCON_LINE_W-1:0] line2;
        } test_vec_t;

        logic                        clk = 1'b0;
        logic                        reset;
        logic                        rot;
        logic [`REGCON_NIBBLE_W-1:0] bits;
        logic [`REGCON_LINE_W-1:0]   line1;
        logic [`REGCON_LINE_W-1:0]   line2;

        test_vec_t                   vec_q[$];
        logic [`REGCON_NIBBLE_W-1:0] step_q[$];
        int                          pass_count = 0;
        int                          fail_count = 0;
        int                          watchdog_cycles = 0;
        logic                        armed = 1'b0;

        always #2 clk = ~clk;

        register_console_top u_register_console_top (
                .clk   (clk),
                .reset (reset),
                .rot   (rot),
                .bits  (bits),
                .line1 (line1),
                .line2 (line2)
        );

        bind op_execute register_console_asserts u_register_console_asserts (
                .clk       (clk),
                .reset     (reset),
                .cmd_valid (cmd_valid),
                .wr        (wr)
        );

        ////////////////////////////////////////////////////////////
        // Knob stimulus
        ////////////////////////////////////////////////////////////

        // Entered one clock after an edge plus 1 ns, left the same way
        task automatic knob_press(input logic [`REGCON_NIBBLE_W-1:0] nibble);
                bits = nibble;
                rot  = 1'b1;
                repeat (3) @(posedge clk);
                #1;
        endtask

        task automatic knob_release();
                rot = 1'b0;
                repeat (3) @(posedge clk);
                #1;
        endtask

        // Low nibble first, then the top address bit alone
        function automatic void queue_addr(input reg_addr_t addr);
                step_q.push_back(addr[3:0]);
                step_q.push_back({3'b000, addr[4]});
        endfunction

        task automatic enter_command(input test_vec_t v);
                step_q.delete();
                step_q.push_back({1'b0, v.op});
                case (v.op)
                        3'd0: begin
                                queue_addr(v.dest);
                                for (int i = 0; i < 4; i++) begin
                                        step_q.push_back(v.data[i*4 +: 4]);
                                end
                        end
                        3'd1: queue_addr(v.src_a);
                        3'd2: begin
                                queue_addr(v.src_a);
                                queue_addr(v.src_b);
                        end
                        3'd5, 3'd6: begin
                                queue_addr(v.src_a);
                                queue_addr(v.src_b);
                                queue_addr(v.dest);
                        end
                        3'd7: begin
                                queue_addr(v.src_a);
                                step_q.push_back(v.src_b[3:0]);
                                queue_addr(v.dest);
                        end
                        default: ;
                endcase
                // Last step stays high, the lines settle two clocks after it
                for (int i = 0; i < step_q.size(); i++) begin
                        knob_press(step_q[i]);
                        if (i < step_q.size() - 1) begin
                                knob_release();
                        end
                end
        endtask

        ////////////////////////////////////////////////////////////
        // Vectors and checks
        ////////////////////////////////////////////////////////////

        task automatic load_vectors();
                int                        fd;
                int                        code;
                int                        n;
                string                     text;
                logic [2:0]                op;
                reg_addr_t                 a;
                reg_addr_t                 b;
                reg_addr_t                 d;
                reg_word_t                 data;
                logic [`REGCON_LINE_W-1:0] exp1;
                logic [`REGCON_LINE_W-1:0] exp2;
                fd = $fopen(VEC_FILE, "r");
                if (fd == 0) begin
                        $display("Cannot open %s", VEC_FILE);
                end else begin
                        while (!$feof(fd)) begin
                                code = $fgets(text, fd);
                                // Skip blank and comment lines
                                if (code > 1 && text.getc(0) != 8'h23) begin
                                        n = $sscanf(text, "%h %h %h %h %h %h %h",
                                                    op, a, b, d, data, exp1, exp2);
                                        if (n == 7) begin
                                                vec_q.push_back('{op, a, b, d, data, exp1, exp2});
                                        end
                                end
                        end
                        $fclose(fd);
                end
        endtask

        task automatic check_lines(input int num, input string label,
                                   input logic [`REGCON_LINE_W-1:0] exp1,
                                   input logic [`REGCON_LINE_W-1:0] exp2);
                int errs;
                errs = 0;
                if (line1 !== exp1) begin
                        $display("FAILED test %0d: line1 = %h, expected %h", num, line1, exp1);
                        errs++;
                end
                if (line2 !== exp2) begin
                        $display("FAILED test %0d: line2 = %h, expected %h", num, line2, exp2);
                        errs++;
                end
                if (errs == 0) begin
                        pass_count++;
                        $display("test %0d (%s) passed", num, label);
                end else begin
                        fail_count++;
                        $display("test %0d (%s) failed", num, label);
                end
        endtask

        ////////////////////////////////////////////////////////////
        // Main sequence and watchdog
        ////////////////////////////////////////////////////////////

        initial begin
                reset = 1'b1;
                rot   = 1'b0;
                bits  = '0;
                load_vectors();
                if (vec_q.size() == 0) begin
                        $display("No test vectors read from %s", VEC_FILE);
                        $display("Errors found");
                        $finish;
                end else begin
                        // A seven step command takes 42 clocks
                        watchdog_cycles = 40 + 60 * vec_q.size();
                        armed = 1'b1;
                        repeat (10) @(posedge clk);
                        #1;
                        reset = 1'b0;
                        check_lines(0, "reset", '0, '0);
                        foreach (vec_q[i]) begin
                                enter_command(vec_q[i]);
                                check_lines(i + 1, $sformatf("op %0d", vec_q[i].op),
                                            vec_q[i].line1, vec_q[i].line2);
                                knob_release();
                        end
                        $display("%0d tests, %0d passed, %0d failed",
                                 pass_count + fail_count, pass_count, fail_count);
                        if (fail_count == 0) begin
                                $display("No errors");
                        end else begin
                                $display("Errors found");
                        end
                        $finish;
                end
        end

        initial begin
                wait (armed);
                repeat (watchdog_cycles) @(posedge clk);
                $display("Timeout after %0d cycles, the command sequence did not complete",
                         watchdog_cycles);
                $display("Errors found");
                $finish;
        end

endmodule

// File: test/register_console_input.txt
# op src_a src_b dest data line1 line2, all hex; src_b is the shift amount for op 7
# line1 and line2 are the expected ASCII display lines, leftmost character first
1 07 00 00 0000 30303030303030303030303030313131 30303030303030303030303030303030
0 00 00 00 1234 30303030303030303030303030303030 30303031303031303030313130313030
0 00 00 1f beef 30303030303030303030303131313131 31303131313131303131313031313131
0 00 00 0a a5c3 30303030303030303030303031303130 31303130303130313131303030303131
0 00 00 11 1234 30303030303030303030303130303031 30303031303031303030313130313030
0 00 00 15 ffff 30303030303030303030303130313031 31313131313131313131313131313131
1 00 00 00 0000 30303030303030303030303030303030 30303031303031303030313130313030
1 1f 00 00 0000 30303030303030303030303131313131 31303131313131303131313031313131
1 0a 00 00 0000 30303030303030303030303031303130 31303130303130313131303030303131
2 1f 0a 00 0000 31303131313131303131313031313131 31303130303130313131303030303131
5 00 11 14 0000 30303030303030303030303130313030 30303030303030303030303030303031
5 00 1f 15 0000 30303030303030303030303130313031 30303030303030303030303030303030
1 14 00 00 0000 30303030303030303030303130313030 30303030303030303030303030303031
1 15 00 00 0000 30303030303030303030303130313031 30303030303030303030303030303030
6 1f 0a 05 0000 30303030303030303030303030313031 30303031313031313030313031313030
1 05 00 00 0000 30303030303030303030303030313031 30303031313031313030313031313030
7 1f 00 06 0000 30303030303030303030303030313130 31303131313131303131313031313131
7 1f 0f 07 0000 30303030303030303030303030313131 30303030303030303030303030303031
7 0a 04 08 0000 30303030303030303030303031303030 30303030313031303031303131313030
1 07 00 00 0000 30303030303030303030303030313131 30303030303030303030303030303031
2 06 08 00 0000 31303131313131303131313031313131 30303030313031303031303131313030
3 00 00 00 0000 31303131313131303131313031313131 30303030313031303031303131313030
1 05 00 00 0000 30303030303030303030303030313031 30303031313031313030313031313030
4 00 00 00 0000 30303030303030303030303030313031 30303031313031313030313031313030
1 08 00 00 0000 30303030303030303030303031303030 30303030313031303031303131313030
1 09 00 00 0000 30303030303030303030303031303031 30303030303030303030303030303030

// File: compile.f
+incdir+include
src/regcon_pkg.sv
src/command_entry.sv
src/reg_file.sv
src/op_execute.sv
src/lcd_line_format.sv
src/register_console_top.sv
test/register_console_asserts.sv
test/register_console_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the register console testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -f compile.f --top-module register_console_tb \
        --Mdir obj_dir -o Vregister_console_tb
if [ $? -ne 0 ]; then
        echo "Verilator build failed"
        exit 1
fi

./obj_dir/Vregister_console_tb > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
        echo "Simulation exited with status $status"
        exit 1
fi

if grep -q "Errors found" "$log"; then
        echo "Simulation reported failures"
        exit 1
fi

echo "Simulation passed"
exit 0
